// ==== hdl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // architectural register number, enough for 32 registers
    typedef logic [4:0] arn_t;

    // physical register number, enough for 64 registers
    typedef logic [5:0] prn_t;

    // free-list occupancy, which has to reach the full depth of 32
    typedef logic [5:0] fl_count_t;

    // number of instructions renamed per cycle
    localparam int default_width = 2;

    localparam int default_phys_regs = 64;

    localparam int default_arch_regs = 32;

    // this register always reads as zero and is never given a new mapping
    localparam arn_t zero_arn = 5'd0;

endpackage

`default_nettype wire

// ==== hdl/rat_free_list.sv ====
`default_nettype none

module rat_free_list #(
    parameter int WIDTH     = rename_pkg::default_width,
    parameter int ARCH_REGS = rename_pkg::default_arch_regs,
    parameter int PHYS_REGS = rename_pkg::default_phys_regs
) (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                squash,
    input  wire        [WIDTH-1:0]             pop_en,
    output rename_pkg::prn_t [WIDTH-1:0]       pop_prn,
    output logic       [WIDTH-1:0]             pop_valid,
    input  wire        [WIDTH-1:0]             free_valid,
    input  wire rename_pkg::prn_t [WIDTH-1:0]  free_prn,
    input  wire rename_pkg::fl_count_t         commit_count
);

    localparam int DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    rename_pkg::prn_t fifo [DEPTH];

    ptr_t spec_head;
    ptr_t ret_head;
    ptr_t tail;
    rename_pkg::fl_count_t spec_count;
    rename_pkg::fl_count_t ret_count;

    rename_pkg::fl_count_t taken;
    rename_pkg::fl_count_t pushed;
    ptr_t push_ptr [WIDTH];

    ptr_t spec_head_next;
    ptr_t ret_head_next;
    rename_pkg::fl_count_t spec_count_next;
    rename_pkg::fl_count_t ret_count_next;

    // moves a pointer forward by n entries around the ring
    function automatic ptr_t advance(input ptr_t ptr, input rename_pkg::fl_count_t n);
        int sum;
        sum = int'(ptr) + int'(n);
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    // pops are handed out in slot order, a slot only gets one if the earlier ones left enough
    always_comb begin
        taken = '0;
        for (int i = 0; i < WIDTH; i++) begin
            pop_valid[i] = 1'b0;
            pop_prn[i]   = '0;
            if (pop_en[i] && (taken < spec_count)) begin
                pop_valid[i] = 1'b1;
                pop_prn[i]   = fifo[advance(spec_head, taken)];
                taken        = taken + 1'b1;
            end
        end
    end

    always_comb begin
        pushed = '0;
        for (int i = 0; i < WIDTH; i++) begin
            push_ptr[i] = advance(tail, pushed);
            if (free_valid[i]) begin
                pushed = pushed + 1'b1;
            end
        end
    end

    assign ret_head_next  = advance(ret_head, commit_count);
    assign ret_count_next = ret_count - commit_count + pushed;

    // a squash throws away every speculative pop since the last commit
    assign spec_head_next  = squash ? ret_head_next : advance(spec_head, taken);
    assign spec_count_next = squash ? ret_count_next : spec_count - taken + pushed;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo[i] <= rename_pkg::prn_t'(ARCH_REGS + i);
            end
            spec_head  <= '0;
            ret_head   <= '0;
            tail       <= '0;
            spec_count <= rename_pkg::fl_count_t'(DEPTH);
            ret_count  <= rename_pkg::fl_count_t'(DEPTH);
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (free_valid[i]) begin
                    fifo[push_ptr[i]] <= free_prn[i];
                end
            end
            spec_head  <= spec_head_next;
            ret_head   <= ret_head_next;
            tail       <= advance(tail, pushed);
            spec_count <= spec_count_next;
            ret_count  <= ret_count_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rat.sv ====
`default_nettype none

module rat #(
    parameter int WIDTH     = rename_pkg::default_width,
    parameter int ARCH_REGS = rename_pkg::default_arch_regs
) (
    input  wire                                    clock,
    input  wire                                    reset,
    input  wire                                    squash,
    input  wire        [WIDTH-1:0]                 dispatch_valid,
    input  wire rename_pkg::arn_t [WIDTH-1:0]      dest_arn,
    input  wire rename_pkg::arn_t [WIDTH-1:0]      op1_arn,
    input  wire rename_pkg::arn_t [WIDTH-1:0]      op2_arn,
    output rename_pkg::prn_t [WIDTH-1:0]           dest_prn,
    output rename_pkg::prn_t [WIDTH-1:0]           op1_prn,
    output rename_pkg::prn_t [WIDTH-1:0]           op2_prn,
    output logic       [WIDTH-1:0]                 pop_en,
    input  wire rename_pkg::prn_t [WIDTH-1:0]      pop_prn,
    input  wire        [WIDTH-1:0]                 pop_valid,
    input  wire rename_pkg::prn_t [ARCH_REGS-1:0]  rrat_table
);

    rename_pkg::prn_t [ARCH_REGS-1:0] rat_table;
    rename_pkg::prn_t [ARCH_REGS-1:0] next_rat_table;

    // kept apart from the lookup so the free-list answer does not loop back into pop_en
    always_comb begin
        pop_en = '0;
        if (!squash) begin
            for (int i = 0; i < WIDTH; i++) begin
                pop_en[i] = dispatch_valid[i] && (dest_arn[i] != rename_pkg::zero_arn);
            end
        end
    end

    // the working copy carries each slot's new mapping on to the younger slots
    always_comb begin
        next_rat_table = rat_table;
        for (int i = 0; i < WIDTH; i++) begin
            dest_prn[i] = '0;
            op1_prn[i]  = '0;
            op2_prn[i]  = '0;
        end

        if (squash) begin
            next_rat_table = rrat_table;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (dispatch_valid[i]) begin
                    op1_prn[i] = next_rat_table[op1_arn[i]];
                    op2_prn[i] = next_rat_table[op2_arn[i]];
                    // pop_en is only high for a non-zero destination
                    if (pop_en[i] && pop_valid[i]) begin
                        next_rat_table[dest_arn[i]] = pop_prn[i];
                        dest_prn[i]                 = pop_prn[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat_table[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            rat_table <= next_rat_table;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rrat.sv ====
`default_nettype none

module rrat #(
    parameter int WIDTH     = rename_pkg::default_width,
    parameter int ARCH_REGS = rename_pkg::default_arch_regs
) (
    input  wire                                clock,
    input  wire                                reset,
    input  wire        [WIDTH-1:0]             commit_valid,
    input  wire rename_pkg::arn_t [WIDTH-1:0]  commit_arn,
    input  wire rename_pkg::prn_t [WIDTH-1:0]  commit_prn,
    output logic       [WIDTH-1:0]             free_valid,
    output rename_pkg::prn_t [WIDTH-1:0]       free_prn,
    output rename_pkg::fl_count_t              commit_count,
    output rename_pkg::prn_t [ARCH_REGS-1:0]   rrat_table
);

    rename_pkg::prn_t [ARCH_REGS-1:0] committed_table;
    rename_pkg::prn_t [ARCH_REGS-1:0] next_committed_table;

    // slots are applied oldest first, so a younger commit to the same register
    // frees the prn that the older one just installed
    always_comb begin
        next_committed_table = committed_table;
        commit_count         = '0;
        for (int i = 0; i < WIDTH; i++) begin
            free_valid[i] = 1'b0;
            free_prn[i]   = '0;
            if (commit_valid[i] && (commit_arn[i] != rename_pkg::zero_arn)) begin
                free_valid[i]                      = 1'b1;
                free_prn[i]                        = next_committed_table[commit_arn[i]];
                next_committed_table[commit_arn[i]] = commit_prn[i];
                commit_count                       = commit_count + 1'b1;
            end
        end
    end

    // a squash in this cycle has to restore a table that already holds this cycle's commits
    assign rrat_table = next_committed_table;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                committed_table[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            committed_table <= next_committed_table;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_top.sv ====
`default_nettype none

module rename_top #(
    parameter int WIDTH     = rename_pkg::default_width,
    parameter int ARCH_REGS = rename_pkg::default_arch_regs,
    parameter int PHYS_REGS = rename_pkg::default_phys_regs
) (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                squash,
    input  wire        [WIDTH-1:0]             dispatch_valid,
    input  wire rename_pkg::arn_t [WIDTH-1:0]  dest_arn,
    input  wire rename_pkg::arn_t [WIDTH-1:0]  op1_arn,
    input  wire rename_pkg::arn_t [WIDTH-1:0]  op2_arn,
    output rename_pkg::prn_t [WIDTH-1:0]       dest_prn,
    output rename_pkg::prn_t [WIDTH-1:0]       op1_prn,
    output rename_pkg::prn_t [WIDTH-1:0]       op2_prn,
    input  wire        [WIDTH-1:0]             commit_valid,
    input  wire rename_pkg::arn_t [WIDTH-1:0]  commit_arn,
    input  wire rename_pkg::prn_t [WIDTH-1:0]  commit_prn
);

    logic             [WIDTH-1:0]     pop_en;
    logic             [WIDTH-1:0]     pop_valid;
    rename_pkg::prn_t [WIDTH-1:0]     pop_prn;
    logic             [WIDTH-1:0]     free_valid;
    rename_pkg::prn_t [WIDTH-1:0]     free_prn;
    rename_pkg::fl_count_t            commit_count;
    rename_pkg::prn_t [ARCH_REGS-1:0] rrat_table;

    rat #(
        .WIDTH(WIDTH),
        .ARCH_REGS(ARCH_REGS)
    ) i_rat (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .dispatch_valid(dispatch_valid),
        .dest_arn(dest_arn),
        .op1_arn(op1_arn),
        .op2_arn(op2_arn),
        .dest_prn(dest_prn),
        .op1_prn(op1_prn),
        .op2_prn(op2_prn),
        .pop_en(pop_en),
        .pop_prn(pop_prn),
        .pop_valid(pop_valid),
        .rrat_table(rrat_table)
    );

    rrat #(
        .WIDTH(WIDTH),
        .ARCH_REGS(ARCH_REGS)
    ) i_rrat (
        .clock(clock),
        .reset(reset),
        .commit_valid(commit_valid),
        .commit_arn(commit_arn),
        .commit_prn(commit_prn),
        .free_valid(free_valid),
        .free_prn(free_prn),
        .commit_count(commit_count),
        .rrat_table(rrat_table)
    );

    rat_free_list #(
        .WIDTH(WIDTH),
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS)
    ) i_rat_free_list (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .pop_en(pop_en),
        .pop_prn(pop_prn),
        .pop_valid(pop_valid),
        .free_valid(free_valid),
        .free_prn(free_prn),
        .commit_count(commit_count)
    );

endmodule

`default_nettype wire

// ==== testbench/rename_assertions.sv ====
`default_nettype none

module rename_assertions #(
    parameter int WIDTH = rename_pkg::default_width,
    parameter int DEPTH = 32
) (
    input wire                                clock,
    input wire                                reset,
    input wire rename_pkg::fl_count_t         spec_count,
    input wire rename_pkg::fl_count_t         ret_count,
    input wire        [WIDTH-1:0]             pop_valid,
    input wire rename_pkg::prn_t [WIDTH-1:0]  pop_prn
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    function automatic logic pop_clash(input logic [WIDTH-1:0] valid,
                                       input rename_pkg::prn_t [WIDTH-1:0] prn);
        logic clash;
        clash = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            for (int j = i + 1; j < WIDTH; j++) begin
                if (valid[i] && valid[j] && prn[i] != '0 && prn[i] == prn[j]) begin
                    clash = 1'b1;
                end
            end
        end
        return clash;
    endfunction

    occupancy_in_range: assert property (@(posedge clock) disable iff (reset)
        (spec_count <= DEPTH) && (ret_count <= DEPTH))
        else begin
            $error("free list occupancy above its depth");
            failures++;
        end

    unique_pops: assert property (@(posedge clock) disable iff (reset)
        !pop_clash(pop_valid, pop_prn))
        else begin
            $error("two slots popped the same physical register");
            failures++;
        end

    full_after_reset: assert property (@(posedge clock) reset |=> (spec_count == DEPTH))
        else begin
            $error("free list not full after reset");
            failures++;
        end

endmodule

`default_nettype wire

// ==== testbench/rename_checker.sv ====
`default_nettype none

module rename_checker #(
    parameter int WIDTH     = rename_pkg::default_width,
    parameter int ARCH_REGS = rename_pkg::default_arch_regs,
    parameter int PHYS_REGS = rename_pkg::default_phys_regs
) (
    input wire                                clock,
    input wire                                reset,
    input wire                                squash,
    input wire        [WIDTH-1:0]             dispatch_valid,
    input wire rename_pkg::arn_t [WIDTH-1:0]  dest_arn,
    input wire rename_pkg::arn_t [WIDTH-1:0]  op1_arn,
    input wire rename_pkg::arn_t [WIDTH-1:0]  op2_arn,
    input wire rename_pkg::prn_t [WIDTH-1:0]  dest_prn,
    input wire rename_pkg::prn_t [WIDTH-1:0]  op1_prn,
    input wire rename_pkg::prn_t [WIDTH-1:0]  op2_prn,
    input wire        [WIDTH-1:0]             commit_valid,
    input wire rename_pkg::arn_t [WIDTH-1:0]  commit_arn,
    input wire rename_pkg::prn_t [WIDTH-1:0]  commit_prn
);

    timeunit 1ns;
    timeprecision 1ps;

    rename_pkg::prn_t spec_map [ARCH_REGS];
    rename_pkg::prn_t commit_map [ARCH_REGS];
    // free registers from the retirement head on, the first spec_taken of them handed out
    rename_pkg::prn_t free_q [$];
    int               spec_taken;
    rename_pkg::prn_t exp_dest [WIDTH];
    int               checks = 0;
    int               errors = 0;

    task automatic compare(input string name, input int slot,
                           input rename_pkg::prn_t expected, input rename_pkg::prn_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s[%0d] expected %0d got %0d", $time, name, slot,
                expected, actual);
        end
    endtask

    task automatic reset_model();
        free_q.delete();
        for (int a = 0; a < ARCH_REGS; a++) begin
            spec_map[a]   = rename_pkg::prn_t'(a);
            commit_map[a] = rename_pkg::prn_t'(a);
        end
        for (int p = ARCH_REGS; p < PHYS_REGS; p++) begin
            free_q.push_back(rename_pkg::prn_t'(p));
        end
        spec_taken = 0;
        for (int i = 0; i < WIDTH; i++) begin
            exp_dest[i] = '0;
        end
    endtask

    task automatic step_model();
        int               taken;
        rename_pkg::prn_t exp_op1;
        rename_pkg::prn_t exp_op2;
        taken = 0;
        for (int i = 0; i < WIDTH; i++) begin
            exp_dest[i] = '0;
            exp_op1     = '0;
            exp_op2     = '0;
            if (dispatch_valid[i] && !squash) begin
                exp_op1 = spec_map[op1_arn[i]];
                exp_op2 = spec_map[op2_arn[i]];
                if (dest_arn[i] != rename_pkg::zero_arn &&
                    spec_taken + taken < free_q.size()) begin
                    exp_dest[i]           = free_q[spec_taken + taken];
                    spec_map[dest_arn[i]] = exp_dest[i];
                    taken++;
                end
            end
            compare("op1_prn", i, exp_op1, op1_prn[i]);
            compare("op2_prn", i, exp_op2, op2_prn[i]);
            compare("dest_prn", i, exp_dest[i], dest_prn[i]);
        end
        spec_taken += taken;
        // a commit retires the entry at the retirement head and frees the old mapping at the tail
        for (int i = 0; i < WIDTH; i++) begin
            if (commit_valid[i] && commit_arn[i] != rename_pkg::zero_arn) begin
                free_q.push_back(commit_map[commit_arn[i]]);
                commit_map[commit_arn[i]] = commit_prn[i];
                void'(free_q.pop_front());
                spec_taken--;
            end
        end
        if (squash) begin
            spec_map   = commit_map;
            spec_taken = 0;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            reset_model();
        end else begin
            step_model();
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rename_tb.sv ====
`default_nettype none

module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH     = rename_pkg::default_width;
    localparam int ARCH_REGS = rename_pkg::default_arch_regs;
    localparam int PHYS_REGS = rename_pkg::default_phys_regs;

    localparam int phase_len [6] = '{100, 300, 300, 200, 500, 600};
    localparam int timeout_cycles = phase_len[0] + phase_len[1] + phase_len[2] +
        phase_len[3] + phase_len[4] + phase_len[5] + 200;

    logic                         clock;
    logic                         reset;
    logic                         squash;
    logic [WIDTH-1:0]             dispatch_valid;
    rename_pkg::arn_t [WIDTH-1:0] dest_arn;
    rename_pkg::arn_t [WIDTH-1:0] op1_arn;
    rename_pkg::arn_t [WIDTH-1:0] op2_arn;
    rename_pkg::prn_t [WIDTH-1:0] dest_prn;
    rename_pkg::prn_t [WIDTH-1:0] op1_prn;
    rename_pkg::prn_t [WIDTH-1:0] op2_prn;
    logic [WIDTH-1:0]             commit_valid;
    rename_pkg::arn_t [WIDTH-1:0] commit_arn;
    rename_pkg::prn_t [WIDTH-1:0] commit_prn;

    logic [31:0]      rng_state = 32'hac80_481d;
    int               cycle_count = 0;
    rename_pkg::arn_t pending_arn [$];
    rename_pkg::prn_t pending_prn [$];
    string            phase_names [6] = '{"identity reads", "fifo allocation",
        "zero destination", "free list exhausted", "commit and reuse", "squash restore"};

    rename_top #(
        .WIDTH(WIDTH),
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS)
    ) i_rename_top (.*);

    rename_checker #(
        .WIDTH(WIDTH),
        .ARCH_REGS(ARCH_REGS),
        .PHYS_REGS(PHYS_REGS)
    ) i_rename_checker (.*);

    bind rat_free_list rename_assertions #(
        .WIDTH(WIDTH),
        .DEPTH(PHYS_REGS - ARCH_REGS)
    ) i_rename_assertions (
        .clock(clock),
        .reset(reset),
        .spec_count(spec_count),
        .ret_count(ret_count),
        .pop_valid(pop_valid),
        .pop_prn(pop_prn)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic drive_cycle(input int phase);
        logic [31:0] r;
        int          n;
        // instructions that the model renamed at the last edge become commit candidates
        for (int i = 0; i < WIDTH; i++) begin
            if (i_rename_checker.exp_dest[i] != '0) begin
                pending_arn.push_back(dest_arn[i]);
                pending_prn.push_back(i_rename_checker.exp_dest[i]);
            end
        end
        r = draw();
        squash = (phase == 6) && (r[3:0] == 4'd0);
        n = (phase == 4) ? 0 : int'(r[9:8]) % (WIDTH + 1);
        for (int i = 0; i < WIDTH; i++) begin
            r = draw();
            dispatch_valid[i] = (r[1:0] != 2'b00);
            dest_arn[i] = r[12:8];
            op1_arn[i]  = r[20:16];
            op2_arn[i]  = r[28:24];
            if (phase == 1) begin
                dest_arn[i] = '0;
            end else if (phase == 2) begin
                // with only eight registers the younger slot often reads the older slot's result
                dest_arn[i] = {2'b00, r[10:8]};
                op1_arn[i]  = {2'b00, r[18:16]};
                op2_arn[i]  = {2'b00, r[26:24]};
            end else if (phase == 3) begin
                dest_arn[i] = {3'b000, r[9:8]};
                op1_arn[i]  = {3'b000, r[17:16]};
            end
            commit_valid[i] = 1'b0;
            commit_arn[i]   = '0;
            commit_prn[i]   = '0;
            if (i < n && pending_arn.size() > 0) begin
                commit_valid[i] = 1'b1;
                commit_arn[i]   = pending_arn.pop_front();
                commit_prn[i]   = pending_prn.pop_front();
            end
        end
        // everything younger than this cycle's commits is thrown away
        if (squash) begin
            pending_arn.delete();
            pending_prn.delete();
        end
    endtask

    initial begin
        int start_checks;
        int start_errors;
        reset          = 1'b1;
        squash         = 1'b0;
        dispatch_valid = '0;
        dest_arn       = '0;
        op1_arn        = '0;
        op2_arn        = '0;
        commit_valid   = '0;
        commit_arn     = '0;
        commit_prn     = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        for (int p = 1; p <= 6; p++) begin
            start_checks = i_rename_checker.checks;
            start_errors = i_rename_checker.errors;
            repeat (phase_len[p-1]) begin
                drive_cycle(p);
                @(negedge clock);
            end
            $display("phase %0d %s: %0d checks, %0d errors", p, phase_names[p-1],
                i_rename_checker.checks - start_checks, i_rename_checker.errors - start_errors);
        end
        $display("total: %0d checks, %0d errors, %0d assertion failures",
            i_rename_checker.checks, i_rename_checker.errors,
            i_rename_top.i_rat_free_list.i_rename_assertions.failures);
        if (i_rename_checker.errors == 0 &&
            i_rename_top.i_rat_free_list.i_rename_assertions.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/rename_pkg.sv
hdl/rat_free_list.sv
hdl/rat.sv
hdl/rrat.sv
hdl/rename_top.sv
testbench/rename_assertions.sv
testbench/rename_checker.sv
testbench/rename_tb.sv

// ==== Makefile ====
SOURCES := $(shell cat sim.f)

obj_dir/Vrename_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f sim.f

sim.log: obj_dir/Vrename_tb
	obj_dir/Vrename_tb > sim.log 2>&1 || true

run: obj_dir/Vrename_tb
	obj_dir/Vrename_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
